/* hw/busPkg.sv */
package busPkg;

  // ####################################################################
  // Bus word and arbitration definitions
  // ####################################################################

  localparam int addressDataWidth = 32;

  // Index of one request bit in the request vector
  typedef logic [1:0] busMasterIndex;

  // Priority order of the masters, a higher index wins the bus
  localparam busMasterIndex dcacheMaster  = 2'd3;
  localparam busMasterIndex icacheMaster  = 2'd2;
  localparam busMasterIndex displayMaster = 2'd1;
  localparam busMasterIndex cameraMaster  = 2'd0;

  // Silent cycles a granted master may spend before the watchdog fires
  localparam int defaultBusTimeoutCycles = 16;

endpackage

/* hw/instructionPkg.sv */
package instructionPkg;

  // ####################################################################
  // Custom-instruction interface of the core
  // ####################################################################

  localparam int ciNumberWidth = 8;
  localparam int ciDataWidth   = 32;

  // Operand and result word
  typedef logic [ciDataWidth-1:0] ciWord;

  // Instruction numbers decoded on ciN
  localparam logic [ciNumberWidth-1:0] swapInstructionNr  = 8'd1;
  localparam logic [ciNumberWidth-1:0] identInstructionNr = 8'd4;
  localparam logic [ciNumberWidth-1:0] delayInstructionNr = 8'd6;

  // Byte swap modes, taken from bit 0 of ciDataB
  localparam logic swapModeFull = 1'b0;
  localparam logic swapModeHalf = 1'b1;

endpackage

/* hw/resetSequencer.sv */
`timescale 1ns/1ps

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReset,
  output logic camnReset
);

  // The top bit sets after sixteen clocks of lock and then freezes the count
  logic [4:0] resetCount;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= 5'd0;
    end else if (!resetCount[4]) begin
      resetCount <= resetCount + 5'd1;
    end
  end

  assign camnReset   = resetCount[4];
  assign systemReset = ~resetCount[4];

endmodule

/* hw/delayInstruction.sv */
`timescale 1ns/1ps

module delayInstruction
  import instructionPkg::*;
#(
  parameter int CyclesPerMicrosecond = 25
) (
  input  logic                     s_systemClock,
  input  logic                     systemReset,
  input  logic                     ciStart,
  input  logic [ciNumberWidth-1:0] ciN,
  input  ciWord                    ciDataA,
  output logic                     ciDone,
  output ciWord                    ciResult
);

  localparam int PrescaleWidth = (CyclesPerMicrosecond > 1) ? $clog2(CyclesPerMicrosecond) : 1;
  localparam logic [PrescaleWidth-1:0] PrescaleTop = PrescaleWidth'(CyclesPerMicrosecond - 1);

  logic                     delayBusy;
  ciWord                    microsecondCount;
  logic [PrescaleWidth-1:0] prescaleCount;
  logic                     startDelay;
  logic                     delayExpired;

  // A start while a delay runs is dropped
  assign startDelay   = ciStart && (ciN == delayInstructionNr) && !delayBusy;
  assign delayExpired = delayBusy && (microsecondCount == '0) && (prescaleCount == '0);

  // ####################################################################
  // Microsecond counter with its cycle prescaler
  // ####################################################################

  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      delayBusy        <= 1'b0;
      microsecondCount <= '0;
      prescaleCount    <= '0;
    end else if (startDelay) begin
      delayBusy <= 1'b1;
      // A zero delay still takes one cycle
      if (ciDataA == '0) begin
        microsecondCount <= '0;
        prescaleCount    <= '0;
      end else begin
        microsecondCount <= ciDataA - 1'b1;
        prescaleCount    <= PrescaleTop;
      end
    end else if (delayExpired) begin
      delayBusy <= 1'b0;
    end else if (delayBusy) begin
      if (prescaleCount == '0) begin
        prescaleCount    <= PrescaleTop;
        microsecondCount <= microsecondCount - 1'b1;
      end else begin
        prescaleCount <= prescaleCount - 1'b1;
      end
    end
  end

  assign ciDone   = delayExpired;
  assign ciResult = '0;

endmodule

/* hw/instructionDispatch.sv */
`timescale 1ns/1ps

module instructionDispatch
  import instructionPkg::*;
#(
  parameter int ClockFrequencyInHz   = 25_000_000,
  parameter int CyclesPerMicrosecond = 25
) (
  input  logic                     s_systemClock,
  input  logic                     systemReset,
  input  logic                     ciStart,
  input  logic [ciNumberWidth-1:0] ciN,
  input  ciWord                    ciDataA,
  input  ciWord                    ciDataB,
  output logic                     ciDone,
  output ciWord                    ciResult
);

  localparam ciWord IdentValue = ciWord'(ClockFrequencyInHz);

  logic  swapSelected;
  logic  identSelected;
  ciWord swapResult;
  ciWord swapContribution;
  ciWord identContribution;
  logic  delayDone;
  ciWord delayResult;

  // ####################################################################
  // Single-cycle instructions
  // ####################################################################

  // Both answer in the start cycle, and not at all while in reset
  assign swapSelected  = ciStart && !systemReset && (ciN == swapInstructionNr);
  assign identSelected = ciStart && !systemReset && (ciN == identInstructionNr);

  always_comb begin
    case (ciDataB[0])
      swapModeHalf: swapResult = {ciDataA[23:16], ciDataA[31:24], ciDataA[7:0], ciDataA[15:8]};
      swapModeFull: swapResult = {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]};
      default:      swapResult = '0;
    endcase
  end

  assign swapContribution  = swapSelected ? swapResult : '0;
  assign identContribution = identSelected ? IdentValue : '0;

  // ####################################################################
  // Multi-cycle instructions
  // ####################################################################

  delayInstruction #(
    .CyclesPerMicrosecond(CyclesPerMicrosecond)
  ) delayUnit (
    .s_systemClock(s_systemClock),
    .systemReset  (systemReset),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDone       (delayDone),
    .ciResult     (delayResult)
  );

  // Idle units keep their lines at zero, so a plain OR merges them
  assign ciDone   = swapSelected | identSelected | delayDone;
  assign ciResult = swapContribution | identContribution | delayResult;

endmodule

/* hw/busArbiter.sv */
`timescale 1ns/1ps

module busArbiter
  import busPkg::*;
#(
  parameter int NumberOfMasters  = 4,
  parameter int BusTimeoutCycles = 16
) (
  input  logic                       s_systemClock,
  input  logic                       systemReset,
  input  logic [NumberOfMasters-1:0] busRequests,
  input  logic                       beginTransaction,
  input  logic                       endTransactionIn,
  input  logic                       dataValid,
  output logic [NumberOfMasters-1:0] busGrants,
  output logic                       busIdle,
  output logic                       busError,
  output logic                       endTransactionOut
);

  localparam int CountWidth = $clog2(BusTimeoutCycles + 1);
  localparam logic [CountWidth-1:0] TimeoutValue = CountWidth'(BusTimeoutCycles);
  localparam logic [NumberOfMasters-1:0] GrantOne = NumberOfMasters'(1);

  logic [NumberOfMasters-1:0] grantReg;
  logic [NumberOfMasters-1:0] nextGrant;
  busMasterIndex              pickIndex;
  logic                       idle;
  logic                       busActivity;
  logic                       timeout;
  logic [CountWidth-1:0]      watchdogCount;

  // ####################################################################
  // Priority pick
  // ####################################################################

  // Later iterations overwrite earlier ones, so the highest index wins
  always_comb begin
    pickIndex = '0;
    for (int i = 0; i < NumberOfMasters; i++) begin
      if (busRequests[i]) begin
        pickIndex = busMasterIndex'(i);
      end
    end
  end

  assign nextGrant = GrantOne << pickIndex;
  assign idle      = (grantReg == '0);

  // ####################################################################
  // Grant register
  // ####################################################################

  // The owner keeps the bus until it ends the transaction or times out
  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      grantReg <= '0;
    end else if (idle) begin
      if (|busRequests) begin
        grantReg <= nextGrant;
      end
    end else if (endTransactionIn || timeout) begin
      grantReg <= '0;
    end
  end

  // ####################################################################
  // Transaction watchdog
  // ####################################################################

  assign busActivity = beginTransaction | dataValid;
  assign timeout     = !idle && (watchdogCount == TimeoutValue);

  always_ff @(posedge s_systemClock or posedge systemReset) begin
    if (systemReset) begin
      watchdogCount <= '0;
    end else if (idle || busActivity || endTransactionIn || timeout) begin
      watchdogCount <= '0;
    end else begin
      watchdogCount <= watchdogCount + 1'b1;
    end
  end

  assign busGrants         = grantReg;
  assign busIdle           = idle;
  // The arbiter closes a stalled transaction itself
  assign busError          = timeout;
  assign endTransactionOut = timeout;

endmodule

/* hw/or1420Subsystem.sv */
`timescale 1ns/1ps

module or1420Subsystem
  import busPkg::*, instructionPkg::*;
#(
  parameter int ClockFrequencyInHz   = 25_000_000,
  parameter int CyclesPerMicrosecond = 25,
  parameter int BusTimeoutCycles     = defaultBusTimeoutCycles,
  parameter int NumberOfMasters      = 4
) (
  input  logic                       s_systemClock,
  input  logic                       s_pllLocked,

  input  logic                       ciStart,
  input  logic [ciNumberWidth-1:0]   ciN,
  input  ciWord                      ciDataA,
  input  ciWord                      ciDataB,
  output logic                       ciDone,
  output ciWord                      ciResult,

  input  logic [NumberOfMasters-1:0] busRequests,
  input  logic                       beginTransaction,
  input  logic                       endTransactionIn,
  input  logic                       dataValid,
  output logic [NumberOfMasters-1:0] busGrants,
  output logic                       busIdle,
  output logic                       busError,
  output logic                       endTransactionOut,

  output logic                       camnReset
);

  logic systemReset;

  // ####################################################################
  // Reset release after clock lock
  // ####################################################################

  resetSequencer resetSeq (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .systemReset  (systemReset),
    .camnReset    (camnReset)
  );

  // ####################################################################
  // Custom instructions
  // ####################################################################

  instructionDispatch #(
    .ClockFrequencyInHz  (ClockFrequencyInHz),
    .CyclesPerMicrosecond(CyclesPerMicrosecond)
  ) ciUnits (
    .s_systemClock(s_systemClock),
    .systemReset  (systemReset),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .ciDone       (ciDone),
    .ciResult     (ciResult)
  );

  // ####################################################################
  // Bus arbitration
  // ####################################################################

  busArbiter #(
    .NumberOfMasters (NumberOfMasters),
    .BusTimeoutCycles(BusTimeoutCycles)
  ) arbiter (
    .s_systemClock    (s_systemClock),
    .systemReset      (systemReset),
    .busRequests      (busRequests),
    .beginTransaction (beginTransaction),
    .endTransactionIn (endTransactionIn),
    .dataValid        (dataValid),
    .busGrants        (busGrants),
    .busIdle          (busIdle),
    .busError         (busError),
    .endTransactionOut(endTransactionOut)
  );

endmodule

/* verification/tbChecker.sv */
`timescale 1ns/1ps

module tbChecker (
  input  logic         s_systemClock,
  input  logic         s_pllLocked,
  input  logic         ciDone,
  input  logic [31:0]  ciResult,
  input  logic         endTransactionIn,
  input  logic [3:0]   busGrants,
  input  logic         busIdle,
  input  logic         busError,
  input  logic         endTransactionOut,
  input  logic         camnReset,
  input  int           testNumber,
  input  int           testKind,
  input  logic [159:0] testName,
  input  logic [31:0]  expFirst,
  input  logic [31:0]  expSecond,
  output int           finishedCount,
  output int           passCount,
  output int           failCount
);

  localparam int WaitLimit = 4000;

  string currentName;
  string failLine;
  int    handled;
  int    waited;
  int    sample;
  int    window;
  int    doneCount;
  int    doneAt;
  int    expectedAt;
  logic [31:0] doneResult;

  task automatic noteMismatch(input string signalName, input logic [31:0] expected, actual);
    if (failLine.len() == 0) begin
      failLine = $sformatf("error at %0d ns in %0s: %0s expected %h actual %h",
                           $time, currentName, signalName, expected, actual);
    end
  endtask

  task automatic notePlain(input string text);
    if (failLine.len() == 0) begin
      failLine = $sformatf("test %0s failed: %0s", currentName, text);
    end
  endtask

  task automatic closeTest();
    if (failLine.len() == 0) begin
      $display("test %0s ok", currentName);
      passCount++;
    end else begin
      $display("%0s", failLine);
      failCount++;
    end
    failLine = "";
    finishedCount++;
  endtask

  // Outputs are sampled on the falling edge, half a cycle away from any change
  initial begin
    passCount = 0;
    failCount = 0;
    finishedCount = 0;
    handled = 0;
    failLine = "";
    currentName = "resetRelease";
    waited = 0;
    @(posedge s_systemClock);
    while (!s_pllLocked && waited < WaitLimit) begin
      @(posedge s_systemClock);
      waited++;
    end
    if (!s_pllLocked) begin
      notePlain("the clock never reported lock");
    end else begin
      // The edge that first sees the lock counts as edge one
      for (int edgeCount = 1; edgeCount <= 16; edgeCount++) begin
        @(negedge s_systemClock);
        if (camnReset !== (edgeCount == 16)) begin
          noteMismatch("camnReset", edgeCount == 16, camnReset);
        end
        if (busGrants !== 4'd0) noteMismatch("busGrants", 0, busGrants);
      end
    end
    closeTest();

    while (waited < WaitLimit) begin
      waited = 0;
      while (testNumber == handled && waited < WaitLimit) begin
        @(negedge s_systemClock);
        waited++;
      end
      if (testNumber != handled) begin
        handled = testNumber;
        currentName = $sformatf("%0s", testName);
        case (testKind)
          1: begin
            window = (expFirst == 32'hffffffff) ? 20 : int'(expFirst) + 20;
            doneCount = 0;
            doneAt = -1;
            doneResult = '0;
            for (sample = 0; sample < window; sample++) begin
              if (sample > 0) @(negedge s_systemClock);
              if (ciDone) begin
                doneCount++;
                if (doneCount == 1) begin
                  doneAt = sample;
                  doneResult = ciResult;
                end
              end
            end
            if (expFirst == 32'hffffffff) begin
              if (doneCount != 0) begin
                notePlain($sformatf("unknown instruction got %0d done", doneCount));
              end
            end else if (doneCount != 1) begin
              notePlain($sformatf("expected one done pulse, saw %0d", doneCount));
            end else begin
              // A registered done seen at sample k is taken by the core on edge k+1
              expectedAt = (expFirst == 0) ? 0 : int'(expFirst) - 1;
              if (doneAt != expectedAt) noteMismatch("ciDone cycle", expectedAt, doneAt);
              if (doneResult !== expSecond) noteMismatch("ciResult", expSecond, doneResult);
            end
          end
          2: begin
            if (busGrants !== expFirst[3:0]) noteMismatch("busGrants", expFirst, busGrants);
            waited = 0;
            while (!endTransactionIn && waited < WaitLimit) begin
              @(negedge s_systemClock);
              waited++;
            end
            if (!endTransactionIn) begin
              notePlain("the granted master never ended its transaction");
            end
            // The edge that saw the end already took the grant away
            if (busGrants !== 4'd0) noteMismatch("busGrants", 0, busGrants);
            if (busIdle !== 1'b1) noteMismatch("busIdle", 1, busIdle);
            @(negedge s_systemClock);
            if (busGrants !== expSecond[3:0]) noteMismatch("busGrants", expSecond, busGrants);
          end
          3: begin
            if (busGrants !== expFirst[3:0]) noteMismatch("busGrants", expFirst, busGrants);
            for (sample = 1; sample <= int'(expSecond) + 1; sample++) begin
              @(negedge s_systemClock);
              if (sample <= int'(expSecond) && busGrants !== expFirst[3:0]) begin
                noteMismatch("busGrants", expFirst, busGrants);
              end
              if (sample < int'(expSecond)) begin
                if (busError !== 1'b0) noteMismatch("busError", 0, busError);
                if (endTransactionOut !== 1'b0) begin
                  noteMismatch("endTransactionOut", 0, endTransactionOut);
                end
              end
              if (sample == int'(expSecond)) begin
                if (busError !== 1'b1) noteMismatch("busError", 1, busError);
                if (endTransactionOut !== 1'b1) begin
                  noteMismatch("endTransactionOut", 1, endTransactionOut);
                end
              end
              if (sample > int'(expSecond)) begin
                if (busGrants !== 4'd0) noteMismatch("busGrants", 0, busGrants);
                if (busError !== 1'b0) noteMismatch("busError", 0, busError);
              end
            end
          end
          default: notePlain("the trace names an unknown test kind");
        endcase
        closeTest();
        waited = 0;
      end
    end
  end

endmodule

/* verification/tbTop.sv */
`timescale 1ns/1ps

module tbTop;

  localparam int WaitLimit = 200;

  logic         s_systemClock;
  logic         s_pllLocked;
  logic         ciStart;
  logic [7:0]   ciN;
  logic [31:0]  ciDataA;
  logic [31:0]  ciDataB;
  logic         ciDone;
  logic [31:0]  ciResult;
  logic [3:0]   busRequests;
  logic         beginTransaction;
  logic         endTransactionIn;
  logic         dataValid;
  logic [3:0]   busGrants;
  logic         busIdle;
  logic         busError;
  logic         endTransactionOut;
  logic         camnReset;

  int           testNumber;
  int           testKind;
  logic [159:0] testName;
  logic [31:0]  expFirst;
  logic [31:0]  expSecond;
  int           finishedCount;
  int           passCount;
  int           failCount;

  integer       seed;
  integer       traceFile;
  int           lineLength;
  string        lineText;
  bit           runAborted;
  logic [159:0] nameField;
  logic [31:0]  kind;
  logic [31:0]  p1;
  logic [31:0]  p2;
  logic [31:0]  p3;
  logic [31:0]  e1;
  logic [31:0]  e2;

  or1420Subsystem dut0 (
    .s_systemClock(s_systemClock), .s_pllLocked(s_pllLocked),
    .ciStart(ciStart), .ciN(ciN), .ciDataA(ciDataA), .ciDataB(ciDataB),
    .ciDone(ciDone), .ciResult(ciResult),
    .busRequests(busRequests), .beginTransaction(beginTransaction),
    .endTransactionIn(endTransactionIn), .dataValid(dataValid),
    .busGrants(busGrants), .busIdle(busIdle), .busError(busError),
    .endTransactionOut(endTransactionOut), .camnReset(camnReset)
  );

  tbChecker checker0 (
    .s_systemClock(s_systemClock), .s_pllLocked(s_pllLocked),
    .ciDone(ciDone), .ciResult(ciResult),
    .endTransactionIn(endTransactionIn), .busGrants(busGrants), .busIdle(busIdle),
    .busError(busError), .endTransactionOut(endTransactionOut), .camnReset(camnReset),
    .testNumber(testNumber), .testKind(testKind), .testName(testName),
    .expFirst(expFirst), .expSecond(expSecond),
    .finishedCount(finishedCount), .passCount(passCount), .failCount(failCount)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #20 s_systemClock = ~s_systemClock;
  end

  task automatic waitForGrant();
    int waited;
    waited = 0;
    @(negedge s_systemClock);
    while (busGrants == '0 && waited < WaitLimit) begin
      @(negedge s_systemClock);
      waited++;
    end
    if (busGrants == '0) begin
      $display("timeout: no bus grant appeared");
      runAborted = 1'b1;
    end
  endtask

  task automatic waitForBusError();
    int waited;
    waited = 0;
    @(negedge s_systemClock);
    while (!busError && waited < WaitLimit) begin
      @(negedge s_systemClock);
      waited++;
    end
    if (!busError) begin
      $display("timeout: the watchdog never raised busError");
      runAborted = 1'b1;
    end
  endtask

  task automatic waitForIdleBus();
    int waited;
    waited = 0;
    while (busGrants != '0 && waited < WaitLimit) begin
      @(negedge s_systemClock);
      waited++;
    end
    if (busGrants != '0) begin
      $display("timeout: the bus grant was never released");
      runAborted = 1'b1;
    end
  endtask

  task automatic waitForChecker(input int target);
    int waited;
    waited = 0;
    @(negedge s_systemClock);
    while (finishedCount < target && waited < WaitLimit) begin
      @(negedge s_systemClock);
      waited++;
    end
    if (finishedCount < target) begin
      $display("timeout: the checker did not finish test %0d", target);
      runAborted = 1'b1;
    end
  endtask

  // A nonzero ciDataB on a delay also fires a second start while it runs
  task automatic runInstruction(input logic [7:0] number, input logic [31:0] a, b);
    ciN     <= number;
    ciDataA <= a;
    ciDataB <= b;
    ciStart <= 1'b1;
    @(negedge s_systemClock);
    ciStart <= 1'b0;
    if (number == 8'd6 && b != '0) begin
      repeat (3) @(negedge s_systemClock);
      ciStart <= 1'b1;
      @(negedge s_systemClock);
      ciStart <= 1'b0;
    end
  endtask

  task automatic runPriority(input logic [3:0] requests);
    logic [3:0] pending;
    pending = requests;
    busRequests <= requests;
    while (pending != '0 && !runAborted) begin
      waitForGrant();
      if (!runAborted) begin
        pending = pending & ~busGrants;
        busRequests      <= pending;
        endTransactionIn <= 1'b1;
        @(negedge s_systemClock);
        endTransactionIn <= 1'b0;
        waitForIdleBus();
      end
    end
  endtask

  // The granted master stays silent until the watchdog ends its transaction
  task automatic runWatchdog(input logic [3:0] requests);
    busRequests <= requests;
    waitForGrant();
    if (!runAborted) begin
      waitForBusError();
      busRequests <= '0;
      waitForIdleBus();
    end
  endtask

  initial begin
    seed = 22;
    runAborted = 1'b0;
    testNumber = 0;
    testKind = 0;
    testName = '0;
    expFirst = '0;
    expSecond = '0;
    s_pllLocked = 1'b0;
    ciStart = 1'b0;
    ciN = '0;
    ciDataA = '0;
    ciDataB = '0;
    // All masters request through reset, so an early release would show a grant
    busRequests = 4'hf;
    beginTransaction = 1'b0;
    endTransactionIn = 1'b0;
    dataValid = 1'b0;
    repeat (2) @(negedge s_systemClock);
    s_pllLocked <= 1'b1;
    repeat (16) @(negedge s_systemClock);
    busRequests <= '0;
    waitForChecker(1);
    traceFile = $fopen("verification/busTrace.txt", "r");
    if (traceFile == 0) begin
      $display("could not open verification/busTrace.txt");
      runAborted = 1'b1;
    end
    while (!runAborted && !$feof(traceFile)) begin
      lineLength = $fgets(lineText, traceFile);
      if (lineLength > 1 && lineText[0] != "#" &&
          $sscanf(lineText, "%s %h %h %h %h %h %h",
                  nameField, kind, p1, p2, p3, e1, e2) == 7) begin
        testName   <= nameField;
        testKind   <= kind;
        expFirst   <= e1;
        expSecond  <= e2;
        testNumber <= testNumber + 1;
        case (kind)
          1: runInstruction(p1[7:0], p2, p3);
          2: runPriority(p1[3:0]);
          3: runWatchdog(p1[3:0]);
          default: ;
        endcase
        if (!runAborted) begin
          waitForChecker(testNumber + 1);
          repeat (($random(seed) & 3) + 1) @(negedge s_systemClock);
        end
      end
    end
    if (traceFile != 0) begin
      $fclose(traceFile);
    end
    repeat (2) @(negedge s_systemClock);
    $display("tests finished %0d, passed %0d, failed %0d", finishedCount, passCount, failCount);
    if (runAborted || failCount != 0 || finishedCount != testNumber + 1) begin
      $display("sim failed");
    end else begin
      $display("sim passed");
    end
    $finish;
  end

endmodule

/* verification/busTrace.txt */
# name kind p1 p2 p3 e1 e2 (all numbers hex)
# kind 1 instruction: p1 ciN, p2 ciDataA, p3 ciDataB, e1 done latency, e2 result
# kind 2 priority: p1 requests, e1 first grant, e2 second grant
# kind 3 watchdog: p1 requests, e1 grant, e2 cycles from grant to busError
swapFull     1 01 12345678 00000000 00000000 78563412
swapHalf     1 01 12345678 00000001 00000000 34127856
swapFullB    1 01 a1b2c3d4 00000002 00000000 d4c3b2a1
swapHalfB    1 01 deadbeef 00000003 00000000 addeefbe
ident        1 04 00000000 00000000 00000000 017d7840
unknownCi    1 09 11111111 00000000 ffffffff 00000000
delayZero    1 06 00000000 00000000 00000001 00000000
delayOne     1 06 00000001 00000000 00000019 00000000
delayThree   1 06 00000003 00000001 0000004b 00000000
priorityAll  2 0f 00000000 00000000 00000008 00000004
priorityMix  2 0b 00000000 00000000 00000008 00000002
priorityLow  2 06 00000000 00000000 00000004 00000002
watchdogOne  3 02 00000000 00000000 00000002 00000010
watchdogTwo  3 0c 00000000 00000000 00000008 00000010

/* filelist.f */
hw/busPkg.sv
hw/instructionPkg.sv
hw/resetSequencer.sv
hw/delayInstruction.sv
hw/instructionDispatch.sv
hw/busArbiter.sv
hw/or1420Subsystem.sv
verification/tbChecker.sv
verification/tbTop.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tbTop -f filelist.f -o tbSim
if [ $? -ne 0 ]; then
  echo "compilation failed"
  exit 1
fi

output=$(./obj_dir/tbSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
